// File: common/rv_pkg.sv
// rv32i subset types: word, opcodes, instruction views, memory request
package rv_pkg;

    // data and byte address word
    typedef logic [31:0] rv_word_t;

    // major opcodes kept from rv32i
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_OPIMM = 7'b0010011,
        OP_STORE = 7'b0100011
    } rv_opcode_e;

    // funct3 codes of the kept operations
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_SW   = 3'b010;

    // i-type layout, addi and lw
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_itype_t;

    // s-type layout, sw
    // immediate split around the register fields
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } rv_stype_t;

    // one fetched word, three views
    // rs1, funct3 and opcode sit at the same bits in both formats
    typedef union packed {
        rv_word_t  raw;
        rv_itype_t i;
        rv_stype_t s;
    } rv_instr_u;

    // core to memory request
    // rd and wr are single-cycle strobes, never both
    typedef struct packed {
        rv_word_t addr;
        rv_word_t wdata;
        logic     rd;
        logic     wr;
    } rv_mem_req_t;

endpackage

// File: common/rv_settings.svh
// memory depth, memory latency and special store address macros
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// memory depth in words
// byte addresses wrap modulo this depth
`define RV_MEM_WORDS 256

// cycles from a sampled request to its ack, at least 1
`define RV_MEM_LATENCY 2

// store here drives the output port
`define RV_OUT_ADDR 32'd1000

// store here stops the core
`define RV_HALT_ADDR 32'd1004

`endif

// File: core/rv_core.sv
// multi-cycle rv32i subset core: fetch/execute fsm, decode, output and halt
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_core import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output rv_mem_req_t mem_req,
    input  rv_word_t    mem_rdata,
    input  logic        mem_ack,
    input  logic        mem_busy,
    output rv_word_t    out_data,
    output logic        out_valid,
    output logic        halt
);

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_WAIT_FETCH,
        ST_WAIT_DATA,
        ST_HALTED
    } state_e;

    state_e     state;
    rv_word_t   pc;
    // instruction held while its data access runs
    rv_instr_u  instr;
    logic [4:0] load_rd;

    // request register, split by reset class
    rv_word_t   req_addr;
    rv_word_t   req_wdata;
    logic       req_rd;
    logic       req_wr;

    // decode of the word on mem_rdata in the fetch ack cycle
    rv_instr_u  fetched;
    rv_word_t   i_imm;
    rv_word_t   s_imm;
    rv_word_t   sum;
    logic       is_addi;
    logic       is_lw;
    logic       is_sw;
    logic       is_out;
    logic       is_halt_st;
    logic       fetch_done;
    logic       data_done;

    // register file hookup
    rv_word_t   rs1_val;
    rv_word_t   rs2_val;
    logic       rf_we;
    logic [4:0] rf_wa;
    rv_word_t   rf_wdata;

    assign fetched = mem_rdata;

    // sign extension, i and s formats
    assign i_imm = {{20{fetched.i.imm[11]}}, fetched.i.imm};
    assign s_imm = {{20{fetched.s.imm_hi[6]}}, fetched.s.imm_hi, fetched.s.imm_lo};

    assign is_addi = (fetched.i.opcode == OP_OPIMM) && (fetched.i.funct3 == F3_ADDI);
    assign is_lw   = (fetched.i.opcode == OP_LOAD) && (fetched.i.funct3 == F3_LW);
    assign is_sw   = (fetched.s.opcode == OP_STORE) && (fetched.s.funct3 == F3_SW);

    // one adder: addi result or effective address
    assign sum = rs1_val + (is_sw ? s_imm : i_imm);

    // stores to the two special addresses never reach memory
    assign is_out     = is_sw && (sum == `RV_OUT_ADDR);
    assign is_halt_st = is_sw && (sum == `RV_HALT_ADDR);

    // mem_busy stays high through the ack cycle
    assign fetch_done = (state == ST_WAIT_FETCH) && mem_ack && mem_busy;
    assign data_done  = (state == ST_WAIT_DATA) && mem_ack && mem_busy;

    // addi writes in the fetch ack cycle, lw in the data ack cycle
    assign rf_we    = (fetch_done && is_addi) ||
                      (data_done && (instr.i.opcode == OP_LOAD));
    assign rf_wa    = data_done ? load_rd : fetched.i.rd;
    assign rf_wdata = data_done ? mem_rdata : sum;

    rv_regfile i_rv_regfile (
        .clk    (clk),
        .rst    (rst),
        .ra1    (fetched.i.rs1),
        .ra2    (fetched.s.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val),
        .we     (rf_we),
        .wa     (rf_wa),
        .wdata  (rf_wdata)
    );

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_FETCH;
            pc        <= '0;
            req_rd    <= 1'b0;
            req_wr    <= 1'b0;
            out_valid <= 1'b0;
            halt      <= 1'b0;
        end else begin
            // strobes default low
            req_rd    <= 1'b0;
            req_wr    <= 1'b0;
            out_valid <= 1'b0;
            case (state)
                ST_FETCH: begin
                    req_rd <= 1'b1;
                    state  <= ST_WAIT_FETCH;
                end
                ST_WAIT_FETCH: begin
                    if (fetch_done) begin
                        if (is_addi || is_out) begin
                            // no data access, straight to next fetch
                            out_valid <= is_out;
                            pc        <= pc + 32'd4;
                            state     <= ST_FETCH;
                        end else if (is_lw) begin
                            req_rd <= 1'b1;
                            state  <= ST_WAIT_DATA;
                        end else if (is_sw && !is_halt_st) begin
                            req_wr <= 1'b1;
                            state  <= ST_WAIT_DATA;
                        end else begin
                            // halt store or unknown encoding
                            halt  <= 1'b1;
                            state <= ST_HALTED;
                        end
                    end
                end
                ST_WAIT_DATA: begin
                    if (data_done) begin
                        pc    <= pc + 32'd4;
                        state <= ST_FETCH;
                    end
                end
                default: begin
                    // halted until reset
                    state <= ST_HALTED;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == ST_FETCH) begin
            req_addr <= pc;
        end else if (fetch_done) begin
            // only used when lw or sw follows
            req_addr <= sum;
        end
        if (fetch_done) begin
            instr     <= fetched;
            load_rd   <= fetched.i.rd;
            req_wdata <= rs2_val;
        end
        if (fetch_done && is_out) begin
            out_data <= rs2_val;
        end
    end

    assign mem_req = '{addr: req_addr, wdata: req_wdata, rd: req_rd, wr: req_wr};

endmodule

// File: core/rv_regfile.sv
// 32 x 32 register file, two async read ports, one sync write port
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic [4:0] ra1,
    input  logic [4:0] ra2,
    output rv_word_t rdata1,
    output rv_word_t rdata2,
    input  logic     we,
    input  logic [4:0] wa,
    input  rv_word_t wdata
);

    // x1..x31 only, x0 has no storage
    rv_word_t regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            // writes to x0 fall through here
            regs[wa] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rdata2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// File: files.f
+incdir+common
common/rv_pkg.sv
core/rv_regfile.sv
core/rv_core.sv
hdl/rv_memory.sv
hdl/rv_system.sv
tests/rv_system_checker.sv
tests/rv_system_tb.sv

// File: hdl/rv_memory.sv
// unified word memory, fixed-latency ack, program load port
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_memory import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  rv_mem_req_t req,
    output rv_word_t    rdata,
    output logic        ack,
    output logic        busy,
    input  logic        load_en,
    input  rv_word_t    load_addr,
    input  rv_word_t    load_data
);

    localparam int WORDS = `RV_MEM_WORDS;
    localparam int LAT   = `RV_MEM_LATENCY;
    localparam int IDX_W = $clog2(WORDS);
    localparam int CNT_W = $clog2(LAT + 1);

    rv_word_t         mem [WORDS];
    // read word held until ack
    rv_word_t         rdata_q;
    logic [CNT_W-1:0] cnt;
    logic             accept;
    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] load_idx;

    // byte address to word index, upper bits wrap
    assign req_idx  = req.addr[IDX_W+1:2];
    assign load_idx = load_addr[IDX_W+1:2];

    // requests while busy are dropped
    assign accept = !busy && (req.rd || req.wr);

    // latency counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            ack  <= 1'b0;
            cnt  <= '0;
        end else begin
            ack <= 1'b0;
            if (busy) begin
                if (ack) begin
                    // transfer done
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt - CNT_W'(1);
                    ack <= (cnt == CNT_W'(1));
                end
            end else if (accept) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(LAT - 1);
                // latency 1 acks in the first busy cycle
                ack  <= (LAT == 1);
            end
        end
    end

    // array and read data, no reset
    always_ff @(posedge clk) begin
        if (load_en) begin
            // load port only used while rst is high
            mem[load_idx] <= load_data;
        end else if (accept && req.wr) begin
            mem[req_idx] <= req.wdata;
        end
        if (accept && req.rd) begin
            rdata_q <= mem[req_idx];
        end
    end

    assign rdata = rdata_q;

endmodule

// File: hdl/rv_system.sv
// top level: core plus unified memory
`timescale 1ns/100ps

module rv_system import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_en,
    input  rv_word_t load_addr,
    input  rv_word_t load_data,
    output rv_word_t out_data,
    output logic     out_valid,
    output logic     halt
);

    // core to memory
    rv_mem_req_t mem_req;
    rv_word_t    mem_rdata;
    logic        mem_ack;
    logic        mem_busy;

    rv_core i_rv_core (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack),
        .mem_busy  (mem_busy),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halt      (halt)
    );

    // program image enters through the load port
    rv_memory i_rv_memory (
        .clk       (clk),
        .rst       (rst),
        .req       (mem_req),
        .rdata     (mem_rdata),
        .ack       (mem_ack),
        .busy      (mem_busy),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: run.sh
#!/bin/sh
# compile and run the rv_system testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module rv_system_tb \
    -o rv_sim

# the pass line decides the result
out=$(./obj_dir/rv_sim) || true
echo "$out"
if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// File: tests/rv_system_checker.sv
// concurrent assertions on rv_system: reset, request strobes, ack and halt
`timescale 1ns/100ps

module rv_system_checker import rv_pkg::*; (
    input logic        clk,
    input logic        rst,
    input rv_mem_req_t mem_req,
    input logic        mem_ack,
    input logic        mem_busy,
    input logic        out_valid,
    input logic        halt
);

    // outputs quiet while reset is held
    a_quiet_in_reset: assert property (
        @(posedge clk) rst |=> (!out_valid && !halt)
    ) else $error("out_valid or halt high while reset is held");

    // read and write strobes are exclusive
    a_single_strobe: assert property (
        @(posedge clk) disable iff (rst) !(mem_req.rd && mem_req.wr)
    ) else $error("memory request with both rd and wr set");

    // one outstanding request, none once halted
    a_req_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req.rd || mem_req.wr) |-> (!mem_busy && !halt)
    ) else $error("memory request issued while busy or halted");

    // ack only inside a transfer
    a_ack_in_busy: assert property (
        @(posedge clk) disable iff (rst) mem_ack |-> mem_busy
    ) else $error("memory ack outside a busy transfer");

    // halt is sticky
    a_halt_sticky: assert property (
        @(posedge clk) disable iff (rst) halt |=> halt
    ) else $error("halt dropped without reset");

endmodule

bind rv_system rv_system_checker i_rv_system_checker (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_busy  (mem_busy),
    .out_valid (out_valid),
    .halt      (halt)
);

// File: tests/rv_system_tb.sv
// testbench for rv_system: program builder, reference model, output monitor, tests
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_system_tb import rv_pkg::*; ();

    localparam int IDX_W = $clog2(`RV_MEM_WORDS);

    logic     clk;
    logic     rst;
    logic     load_en;
    rv_word_t load_addr;
    rv_word_t load_data;
    rv_word_t out_data;
    logic     out_valid;
    logic     halt;

    int       seed;
    // program image of the current test
    rv_word_t prog_q [$];
    // expected output words from the model
    rv_word_t exp_q [$];
    logic     exp_halt;
    string    cur_name;
    int       out_idx;
    int       checks;
    int       errors;
    int       tests;
    int       failed_tests;

    // model state
    rv_word_t m_regs [32];
    rv_word_t m_mem [`RV_MEM_WORDS];

    rv_system i_rv_system (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halt      (halt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // rv32i encodings
    function automatic rv_word_t addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        rv_instr_u w;
        w.raw      = '0;
        w.i.opcode = OP_OPIMM;
        w.i.funct3 = 3'b000;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm    = imm;
        return w.raw;
    endfunction

    function automatic rv_word_t lw_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        rv_instr_u w;
        w.raw      = '0;
        w.i.opcode = OP_LOAD;
        w.i.funct3 = 3'b010;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm    = imm;
        return w.raw;
    endfunction

    function automatic rv_word_t sw_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        rv_instr_u w;
        w.raw        = '0;
        w.s.opcode   = OP_STORE;
        w.s.funct3   = 3'b010;
        w.s.rs1      = rs1;
        w.s.rs2      = rs2;
        w.s.imm_hi   = imm[11:5];
        w.s.imm_lo   = imm[4:0];
        return w.raw;
    endfunction

    // sw rs, 1000(x0)
    function automatic rv_word_t out_word(logic [4:0] rs);
        return sw_word(rs, 5'd0, 12'(`RV_OUT_ADDR));
    endfunction

    // sw x0, 1004(x0)
    function automatic rv_word_t stop_word();
        return sw_word(5'd0, 5'd0, 12'(`RV_HALT_ADDR));
    endfunction

    function automatic rv_word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // byte address to word slot, wraps with the depth
    function automatic logic [IDX_W-1:0] word_index(rv_word_t a);
        return IDX_W'(a >> 2);
    endfunction

    // ISA-level model of prog_q, fills exp_q, returns the halt flag
    function automatic logic ref_run();
        rv_instr_u w;
        rv_word_t  pc;
        rv_word_t  addr;
        logic      stop;
        int        steps;
        m_regs = '{default: '0};
        m_mem  = '{default: '0};
        for (int i = 0; i < prog_q.size(); i++) begin
            m_mem[word_index(rv_word_t'(i * 4))] = prog_q[i];
        end
        exp_q.delete();
        pc    = '0;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < 1000) begin
            w     = m_mem[word_index(pc)];
            pc    = pc + 32'd4;
            steps = steps + 1;
            if (w.i.opcode == OP_OPIMM && w.i.funct3 == 3'b000) begin
                // x0 never written
                if (w.i.rd != 5'd0) begin
                    m_regs[w.i.rd] = m_regs[w.i.rs1] + sext12(w.i.imm);
                end
            end else if (w.i.opcode == OP_LOAD && w.i.funct3 == 3'b010) begin
                addr = m_regs[w.i.rs1] + sext12(w.i.imm);
                if (w.i.rd != 5'd0) begin
                    m_regs[w.i.rd] = m_mem[word_index(addr)];
                end
            end else if (w.s.opcode == OP_STORE && w.s.funct3 == 3'b010) begin
                addr = m_regs[w.s.rs1] + sext12({w.s.imm_hi, w.s.imm_lo});
                if (addr == `RV_OUT_ADDR) begin
                    exp_q.push_back(m_regs[w.s.rs2]);
                end else if (addr == `RV_HALT_ADDR) begin
                    stop = 1'b1;
                end else begin
                    m_mem[word_index(addr)] = m_regs[w.s.rs2];
                end
            end else begin
                // anything else stops the core
                stop = 1'b1;
            end
        end
        return stop;
    endfunction

    task automatic check_word(string what, rv_word_t exp, rv_word_t act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_halt(string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", cur_name, what, exp, act);
            errors++;
        end
    endtask

    // output monitor, in-order compare against the model
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (out_idx < exp_q.size()) begin
                check_word($sformatf("out %0d", out_idx), exp_q[out_idx], out_data);
            end else begin
                $display("ERROR %s: unexpected output word %h after %0d expected words",
                         cur_name, out_data, exp_q.size());
                errors++;
            end
            out_idx++;
        end
    end

    // load prog_q under reset, run to halt, then watch a quiet window
    task automatic run_test(string name);
        int cyc;
        int err_before;
        cur_name   = name;
        err_before = errors;
        exp_halt   = ref_run();
        out_idx    = 0;
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < prog_q.size(); i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= rv_word_t'(i * 4);
            load_data <= prog_q[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        cyc = 0;
        while (!halt && cyc < 2000) begin
            @(negedge clk);
            cyc++;
        end
        if (!halt) begin
            $display("ERROR %s: core did not halt within %0d cycles", name, cyc);
            errors++;
        end
        check_halt("halt", exp_halt, halt);
        // no output and no release of halt afterwards
        repeat (16) @(negedge clk);
        check_halt("halt held", exp_halt, halt);
        check_word("output count", rv_word_t'(exp_q.size()), rv_word_t'(out_idx));
        tests++;
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("test %s: %s, %0d outputs", name, (errors == err_before) ? "ok" : "errors", out_idx);
    endtask

    // random addi chain over x1..x8, then output all of them
    task automatic addi_chain_prog();
        logic [4:0] rd;
        logic [4:0] rs;
        prog_q.delete();
        for (int k = 0; k < 14; k++) begin
            rd = 5'(($random(seed) & 32'h7) + 1);
            rs = 5'($random(seed) & 32'h7);
            prog_q.push_back(addi_word(rd, rs, 12'($random(seed))));
        end
        for (int r = 1; r <= 8; r++) begin
            prog_q.push_back(out_word(5'(r)));
        end
        prog_q.push_back(stop_word());
    endtask

    task automatic x0_prog();
        prog_q.delete();
        prog_q.push_back(addi_word(5'd0, 5'd0, 12'h7ff));
        prog_q.push_back(addi_word(5'd3, 5'd0, 12'hff7));
        prog_q.push_back(addi_word(5'd0, 5'd3, 12'h123));
        prog_q.push_back(out_word(5'd0));
        prog_q.push_back(out_word(5'd3));
        prog_q.push_back(stop_word());
    endtask

    // stores around base 640, loads back into x10..x15
    task automatic mem_prog();
        logic [11:0] off [6];
        int          r;
        prog_q.delete();
        prog_q.push_back(addi_word(5'd20, 5'd0, 12'd640));
        for (int k = 0; k < 6; k++) begin
            r      = $random(seed) % 8;
            // distinct slots, signed offsets
            off[k] = 12'(r * 32 + k * 4);
            prog_q.push_back(addi_word(5'(k + 1), 5'(k), 12'($random(seed))));
            prog_q.push_back(sw_word(5'(k + 1), 5'd20, off[k]));
        end
        for (int k = 0; k < 6; k++) begin
            prog_q.push_back(lw_word(5'(k + 10), 5'd20, off[k]));
            prog_q.push_back(out_word(5'(k + 10)));
        end
        prog_q.push_back(stop_word());
    endtask

    task automatic halt_prog();
        prog_q.delete();
        prog_q.push_back(addi_word(5'd1, 5'd0, 12'($random(seed))));
        prog_q.push_back(out_word(5'd1));
        prog_q.push_back(stop_word());
        // never reached
        prog_q.push_back(out_word(5'd1));
        prog_q.push_back(addi_word(5'd1, 5'd1, 12'd1));
        prog_q.push_back(out_word(5'd1));
    endtask

    task automatic unknown_op_prog();
        prog_q.delete();
        prog_q.push_back(addi_word(5'd1, 5'd0, 12'($random(seed))));
        prog_q.push_back(addi_word(5'd2, 5'd1, 12'($random(seed))));
        prog_q.push_back(out_word(5'd1));
        prog_q.push_back(out_word(5'd2));
        // reserved opcode, random upper bits
        prog_q.push_back({25'($random(seed)), 7'b1111111});
        prog_q.push_back(out_word(5'd1));
        prog_q.push_back(stop_word());
    endtask

    initial begin
        seed         = 32'hd0ef_4128;
        rst          = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        out_idx      = 0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        cur_name     = "reset";
        repeat (4) @(posedge clk);
        addi_chain_prog();
        run_test("addi_chain");
        x0_prog();
        run_test("x0_write");
        mem_prog();
        run_test("store_load");
        halt_prog();
        run_test("halt_store");
        unknown_op_prog();
        run_test("unknown_opcode");
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
